/* run_sim.sh */
#!/bin/sh
# Build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f \
   --top-module tb_cache \
   -o Vtb_cache

status=0
output=$(./obj_dir/Vtb_cache 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
   exit 0
fi

echo "Simulation did not pass (exit status $status)"
exit 1

/* sources.f */
+incdir+verif
verilog/mem_pkg.sv
verilog/cache_pkg.sv
verilog/mem_bus_if.sv
verilog/main_memory.sv
verilog/cache_array.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verif/tb_cache.sv

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////
// Model state
////////////////////////////////////////////////////////////

// Main memory image, word addressed, starts at zero
mem_pkg::word_t model_mem [1 << (mem_pkg::ADDR_BITS - 1)];

// Expected tag and valid per set
logic [cache_pkg::TAG_BITS-1:0] model_tag   [cache_pkg::SETS];
logic                           model_valid [cache_pkg::SETS];

int error_count;

// Set index of a byte address
function automatic int unsigned set_of(input mem_pkg::addr_t a);
   return a[1 + cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
endfunction

// Tag of a byte address
function automatic logic [cache_pkg::TAG_BITS-1:0] tag_of(input mem_pkg::addr_t a);
   return a[mem_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
endfunction

task automatic clear_model();
   for (int i = 0; i < $size(model_mem); i++) begin
      model_mem[i] = '0;
   end
   for (int s = 0; s < cache_pkg::SETS; s++) begin
      model_tag[s]   = '0;
      model_valid[s] = 1'b0;
   end
endtask

////////////////////////////////////////////////////////////
// Prediction
////////////////////////////////////////////////////////////

// One request applied to the model, gives latency and read word
task automatic predict(input logic is_wr, input mem_pkg::addr_t a,
                       input mem_pkg::word_t wd, output int lat,
                       output mem_pkg::word_t rd, output logic was_hit,
                       output logic conflict);
   int unsigned                    s;
   logic [cache_pkg::TAG_BITS-1:0] t;
   s        = set_of(a);
   t        = tag_of(a);
   was_hit  = model_valid[s] && (model_tag[s] == t);
   conflict = model_valid[s] && !was_hit;
   rd       = model_mem[a[mem_pkg::ADDR_BITS-1:1]];
   if (is_wr) begin
      // Write through, no allocation on a miss
      lat = 1;
      model_mem[a[mem_pkg::ADDR_BITS-1:1]] = wd;
   end else if (was_hit) begin
      lat = 1;
   end else begin
      // Fill replaces whatever the set held
      lat            = MISS_LATENCY;
      model_valid[s] = 1'b1;
      model_tag[s]   = t;
   end
endtask

////////////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////////////

task automatic check_value(input string name, input int exp, input int act);
   assert (exp == act) else begin
      error_count++;
      $display("[ERROR] %s, request %0d: expected 0x%0h, actual 0x%0h",
               name, req_num, exp, act);
      stop_with_failure();
   end
endtask

task automatic expect_true(input logic cond, input string what);
   assert (cond) else begin
      error_count++;
      $display("%s (request %0d)", what, req_num);
      stop_with_failure();
   end
endtask

`endif

/* verif/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

   localparam int READ_LATENCY = 4;
   localparam int NUM_REQS     = 1500;

   // Four issue cycles, the memory pipeline, then the answer cycle
   localparam int MISS_LATENCY = cache_pkg::BLOCK_WORDS + READ_LATENCY + 1;

   // Worst request is the miss plus its req cycle
   localparam int TIMEOUT_CYCLES = NUM_REQS * 10 + 100;

   // Address pool of 64 words: 4 tags, 4 sets, 4 words each
   localparam int POOL_TAGS = 4;
   localparam int POOL_SETS = 4;

   logic           clk;
   logic           rst;
   logic           req;
   logic           wr;
   mem_pkg::addr_t addr;
   mem_pkg::word_t wdata;
   mem_pkg::word_t rdata;
   logic           done;
   logic           busy;

   integer seed;
   int     cycle_count;
   int     req_num;

   // Coverage of access kinds
   int rd_hits;
   int rd_misses;
   int conflicts;
   int wr_hits;
   int wr_misses;
   int readbacks;

   cache_top #(
      .READ_LATENCY (READ_LATENCY)
   ) DUT (
      .clk   (clk),
      .rst   (rst),
      .req   (req),
      .wr    (wr),
      .addr  (addr),
      .wdata (wdata),
      .rdata (rdata),
      .done  (done),
      .busy  (busy)
   );

   always #5 clk = ~clk;

   task automatic stop_with_failure();
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   `include "tb_model.svh"

   ////////////////////////////////////////////////////////////
   // Timeout
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   ////////////////////////////////////////////////////////////
   // One CPU request
   ////////////////////////////////////////////////////////////

   task automatic run_request(input logic is_wr, input mem_pkg::addr_t a,
                              input mem_pkg::word_t wd);
      int             exp_lat;
      int             lat;
      mem_pkg::word_t exp_rd;
      logic           was_hit;
      logic           conflict;
      string          name;
      predict(is_wr, a, wd, exp_lat, exp_rd, was_hit, conflict);
      if (is_wr) begin
         name = "write_latency";
         if (was_hit) wr_hits++;
         else wr_misses++;
      end else begin
         name = "read_latency";
         if (was_hit) rd_hits++;
         else rd_misses++;
         if (conflict) conflicts++;
      end
      @(posedge clk);
      req   <= 1'b1;
      wr    <= is_wr;
      addr  <= a;
      wdata <= wd;
      // Req cycle, previous done already gone
      @(negedge clk);
      expect_true(!done && !busy, "done or busy high in the request cycle");
      @(posedge clk);
      req <= 1'b0;
      lat = 1;
      @(negedge clk);
      while (!done) begin
         expect_true(busy, "busy low while waiting for done");
         lat++;
         @(negedge clk);
      end
      expect_true(busy, "busy low in the done cycle");
      check_value(name, exp_lat, lat);
      if (!is_wr) begin
         check_value("read_data", exp_rd, rdata);
      end
      req_num++;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin : stimulus
      logic                              is_wr;
      logic                              last_was_wr;
      mem_pkg::addr_t                    a;
      mem_pkg::addr_t                    last_addr;
      mem_pkg::word_t                    wd;
      logic [cache_pkg::TAG_BITS-1:0]    t_sel;
      logic [cache_pkg::INDEX_BITS-1:0]  s_sel;
      logic [cache_pkg::OFFSET_BITS-1:0] o_sel;
      clk         = 1'b0;
      rst         = 1'b1;
      req         = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      wdata       = '0;
      seed        = 93;
      cycle_count = 0;
      req_num     = 0;
      error_count = 0;
      rd_hits     = 0;
      rd_misses   = 0;
      conflicts   = 0;
      wr_hits     = 0;
      wr_misses   = 0;
      readbacks   = 0;
      last_was_wr = 1'b0;
      last_addr   = '0;
      clear_model();

      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // Quiet after reset
      repeat (4) begin
         @(negedge clk);
         expect_true(!done && !busy, "done or busy high after reset");
      end

      for (int i = 0; i < NUM_REQS; i++) begin
         is_wr = ($unsigned($random(seed)) % 5) < 2;
         t_sel = $unsigned($random(seed)) % POOL_TAGS;
         s_sel = $unsigned($random(seed)) % POOL_SETS;
         o_sel = $unsigned($random(seed)) % cache_pkg::BLOCK_WORDS;
         wd    = $random(seed);
         a     = {t_sel, s_sel, o_sel, 1'b0};
         // Often read back what was just written
         if (!is_wr && last_was_wr && $random(seed) % 2 == 0) begin
            a = last_addr;
            readbacks++;
         end
         run_request(is_wr, a, wd);
         last_was_wr = is_wr;
         last_addr   = a;
      end

      // Each access kind must have occurred
      expect_true(rd_hits > 0, "no read hits were generated");
      expect_true(rd_misses > 0, "no read misses were generated");
      expect_true(conflicts > 0, "no conflicting fills were generated");
      expect_true(wr_hits > 0, "no write hits were generated");
      expect_true(wr_misses > 0, "no write misses were generated");
      expect_true(readbacks > 0, "no reads after writes were generated");

      @(posedge clk);
      if (error_count == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

endmodule

/* verilog/cache_array.sv */
`timescale 1ns/1ps

module cache_array (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [cache_pkg::INDEX_BITS-1:0]  index,
   input  logic [cache_pkg::TAG_BITS-1:0]    tag,
   input  logic [cache_pkg::OFFSET_BITS-1:0] offset,
   input  logic                              word_we,
   input  mem_pkg::word_t                    word_wdata,
   input  logic                              fill_done,
   output logic                              hit,
   output mem_pkg::word_t                    rdata
);

   localparam int WSEL_BITS = cache_pkg::INDEX_BITS + cache_pkg::OFFSET_BITS;

   // Per-set tag and valid
   logic [cache_pkg::TAG_BITS-1:0] tags [cache_pkg::SETS];
   logic [cache_pkg::SETS-1:0]     valid;

   // Block words, set-major
   mem_pkg::word_t blk_data [cache_pkg::SETS * cache_pkg::BLOCK_WORDS];

   logic [WSEL_BITS-1:0] word_sel;

   assign word_sel = {index, offset};

   ////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////

   // Combinational hit and word read
   assign hit   = valid[index] && (tags[index] == tag);
   assign rdata = blk_data[word_sel];

   ////////////////////////////////////////////////////////////
   // Update
   ////////////////////////////////////////////////////////////

   // Valid bits cleared on reset, set when a block fill lands
   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= '0;
      end else if (fill_done) begin
         valid[index] <= 1'b1;
      end
   end

   // Tag goes in with the last fill word
   always_ff @(posedge clk) begin
      if (fill_done) begin
         tags[index] <= tag;
      end
   end

   // One word per cycle, from a fill or a write hit
   always_ff @(posedge clk) begin
      if (word_we) begin
         blk_data[word_sel] <= word_wdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Tag is only set together with the last data word
   a_fill_with_word: assert property (@(posedge clk) disable iff (rst)
      fill_done |-> word_we);

endmodule

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                              clk,
   input  logic                              rst,
   // CPU side
   input  logic                              req,
   input  logic                              wr,
   input  mem_pkg::addr_t                    addr,
   input  mem_pkg::word_t                    wdata,
   output mem_pkg::word_t                    rdata,
   output logic                              done,
   output logic                              busy,
   // Main memory
   mem_bus_if.ctrl                           mem,
   // Cache array
   output logic [cache_pkg::INDEX_BITS-1:0]  index,
   output logic [cache_pkg::TAG_BITS-1:0]    tag,
   output logic [cache_pkg::OFFSET_BITS-1:0] offset,
   output logic                              word_we,
   output mem_pkg::word_t                    word_wdata,
   output logic                              fill_done,
   input  logic                              hit,
   input  mem_pkg::word_t                    arr_rdata
);

   cache_pkg::ctrl_state_e state;

   // Registered request
   cache_pkg::cache_addr_u req_q;
   logic                   req_wr_q;
   mem_pkg::word_t         req_wdata_q;

   // Fill bookkeeping
   logic [cache_pkg::OFFSET_BITS-1:0] issue_cnt;
   logic [cache_pkg::OFFSET_BITS-1:0] ret_cnt;
   cache_pkg::cache_addr_u            fill_addr;
   mem_pkg::word_t                    fill_word;
   logic                              fill_ret;
   logic                              fill_active;
   logic                              word_ret;
   logic                              lookup_miss;

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   assign index = req_q.f.index;
   assign tag   = req_q.f.tag;

   assign fill_active = (state == cache_pkg::fill_issue) || (state == cache_pkg::fill_wait);
   assign word_ret    = fill_active && mem.data_valid;

   // Read miss seen in the lookup cycle, not on the return after a fill
   assign lookup_miss = (state == cache_pkg::respond) && !req_wr_q && !hit && !fill_ret;

   // Block address of the next read to issue
   always_comb begin
      fill_addr            = req_q;
      fill_addr.f.offset   = issue_cnt;
      fill_addr.f.byte_sel = 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // Memory requests
   ////////////////////////////////////////////////////////////

   always_comb begin
      mem.enable = 1'b0;
      mem.wr     = 1'b0;
      mem.addr   = fill_addr.flat;
      mem.wdata  = req_wdata_q;
      case (state)
         cache_pkg::respond: begin
            if (req_wr_q) begin
               // Write through, hit or miss
               mem.enable = 1'b1;
               mem.wr     = 1'b1;
               mem.addr   = req_q.flat;
            end else if (lookup_miss) begin
               // First read of the block
               mem.enable = 1'b1;
            end
         end
         cache_pkg::fill_issue: begin
            mem.enable = 1'b1;
         end
         default: begin
            mem.enable = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Array controls
   ////////////////////////////////////////////////////////////

   // Returning words land at the return counter
   assign offset     = fill_active ? ret_cnt : req_q.f.offset;
   assign word_we    = word_ret || ((state == cache_pkg::respond) && req_wr_q && hit);
   assign word_wdata = word_ret ? mem.rdata : req_wdata_q;
   assign fill_done  = word_ret && (&ret_cnt);

   // CPU outputs
   assign done  = (state == cache_pkg::respond) && !lookup_miss;
   assign busy  = state != cache_pkg::idle;
   assign rdata = fill_ret ? fill_word : arr_rdata;

   ////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= cache_pkg::idle;
         issue_cnt <= '0;
         ret_cnt   <= '0;
         fill_ret  <= 1'b0;
      end else begin
         case (state)
            cache_pkg::idle: begin
               if (req) begin
                  state <= cache_pkg::respond;
               end
            end
            cache_pkg::respond: begin
               if (lookup_miss) begin
                  state     <= cache_pkg::fill_issue;
                  issue_cnt <= issue_cnt + 1'b1;
               end else begin
                  state    <= cache_pkg::idle;
                  fill_ret <= 1'b0;
               end
            end
            cache_pkg::fill_issue: begin
               // Counter wraps back to zero after the last offset
               issue_cnt <= issue_cnt + 1'b1;
               if (&issue_cnt) begin
                  state <= cache_pkg::fill_wait;
               end
            end
            cache_pkg::fill_wait: begin
               if (fill_done) begin
                  state    <= cache_pkg::respond;
                  fill_ret <= 1'b1;
               end
            end
            default: begin
               state <= cache_pkg::idle;
            end
         endcase
         // Count returns, also wraps after four
         if (word_ret) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   // Request capture
   always_ff @(posedge clk) begin
      if ((state == cache_pkg::idle) && req) begin
         req_q.flat  <= addr;
         req_wr_q    <= wr;
         req_wdata_q <= wdata;
      end
   end

   // Keep the requested word as it streams past
   always_ff @(posedge clk) begin
      if (word_ret && (ret_cnt == req_q.f.offset)) begin
         fill_word <= mem.rdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // No back-pressure, CPU must wait for done
   a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
      busy |-> !req);

endmodule

/* verilog/cache_pkg.sv */
// Cache geometry and controller types

package cache_pkg;

   ////////////////////////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////////////////////////

   // Four words per block
   localparam int OFFSET_BITS = 2;

   // Sixteen sets
   localparam int INDEX_BITS = 4;

   // Whatever is left above byte, offset and index
   localparam int TAG_BITS = mem_pkg::ADDR_BITS - 1 - OFFSET_BITS - INDEX_BITS;

   localparam int BLOCK_WORDS = 1 << OFFSET_BITS;
   localparam int SETS        = 1 << INDEX_BITS;

   ////////////////////////////////////////////////////////////
   // Address views
   ////////////////////////////////////////////////////////////

   // Lookup fields, MSB first
   typedef struct packed {
      logic [TAG_BITS-1:0]    tag;
      logic [INDEX_BITS-1:0]  index;
      logic [OFFSET_BITS-1:0] offset;
      logic                   byte_sel;
   } addr_fields_t;

   // Same byte address, flat toward memory or split for lookup
   typedef union packed {
      mem_pkg::addr_t flat;
      addr_fields_t   f;
   } cache_addr_u;

   // Controller states
   typedef enum logic [1:0] {
      idle,
      respond,
      fill_issue,
      fill_wait
   } ctrl_state_e;

endpackage

/* verilog/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
   parameter int MEM_WORDS    = 32768,
   parameter int READ_LATENCY = 4
) (
   input  logic           clk,
   input  logic           rst,
   input  logic           req,
   input  logic           wr,
   input  mem_pkg::addr_t addr,
   input  mem_pkg::word_t wdata,
   output mem_pkg::word_t rdata,
   output logic           done,
   output logic           busy
);

   // Controller to array
   logic [cache_pkg::INDEX_BITS-1:0]  index;
   logic [cache_pkg::TAG_BITS-1:0]    tag;
   logic [cache_pkg::OFFSET_BITS-1:0] offset;
   logic                              word_we;
   mem_pkg::word_t                    word_wdata;
   logic                              fill_done;
   logic                              hit;
   mem_pkg::word_t                    arr_rdata;

   // Controller to memory
   mem_bus_if bus ();

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .req        (req),
      .wr         (wr),
      .addr       (addr),
      .wdata      (wdata),
      .rdata      (rdata),
      .done       (done),
      .busy       (busy),
      .mem        (bus),
      .index      (index),
      .tag        (tag),
      .offset     (offset),
      .word_we    (word_we),
      .word_wdata (word_wdata),
      .fill_done  (fill_done),
      .hit        (hit),
      .arr_rdata  (arr_rdata)
   );

   cache_array u_array (
      .clk        (clk),
      .rst        (rst),
      .index      (index),
      .tag        (tag),
      .offset     (offset),
      .word_we    (word_we),
      .word_wdata (word_wdata),
      .fill_done  (fill_done),
      .hit        (hit),
      .rdata      (arr_rdata)
   );

   main_memory #(
      .MEM_WORDS    (MEM_WORDS),
      .READ_LATENCY (READ_LATENCY)
   ) u_mem (
      .clk (clk),
      .rst (rst),
      .bus (bus)
   );

endmodule

/* verilog/main_memory.sv */
`timescale 1ns/1ps

module main_memory #(
   parameter int MEM_WORDS    = 32768,
   parameter int READ_LATENCY = 4
) (
   input  logic  clk,
   input  logic  rst,
   mem_bus_if.mem bus
);

   // Word index width, upper address bits beyond the depth are dropped
   localparam int IDX_BITS = $clog2(MEM_WORDS);

   mem_pkg::word_t words [MEM_WORDS];

   logic [IDX_BITS-1:0] word_idx;
   logic                rd_en;

   // Read return chain, stage 0 is loaded in the request cycle
   logic [READ_LATENCY-1:0] valid_pipe;
   mem_pkg::word_t          data_pipe [READ_LATENCY];

   // Byte address, drop bit 0
   assign word_idx = bus.addr[IDX_BITS:1];
   assign rd_en    = bus.enable && !bus.wr;

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // Contents start at zero
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         words[i] = '0;
      end
   end

   // Single-cycle write
   always @(posedge clk) begin
      if (bus.enable && bus.wr) begin
         words[word_idx] <= bus.wdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read pipeline
   ////////////////////////////////////////////////////////////

   // Each stage moves every cycle, so back-to-back reads overlap
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_pipe <= '0;
         for (int i = 0; i < READ_LATENCY; i++) begin
            data_pipe[i] <= '0;
         end
      end else begin
         valid_pipe[0] <= rd_en;
         data_pipe[0]  <= rd_en ? words[word_idx] : '0;
         for (int i = 1; i < READ_LATENCY; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
            data_pipe[i]  <= data_pipe[i-1];
         end
      end
   end

   // Last stage is the return
   assign bus.data_valid = valid_pipe[READ_LATENCY-1];
   assign bus.rdata      = data_pipe[READ_LATENCY-1];

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Word accesses only
   a_addr_even: assert property (@(posedge clk) disable iff (rst)
      bus.enable |-> !bus.addr[0]);

   // Nothing comes out of the chain until a full latency past reset
   for (genvar k = 1; k <= READ_LATENCY; k++) begin : g_rst_quiet
      a_no_valid_after_rst: assert property (@(posedge clk)
         bus.data_valid |-> !$past(rst, k));
   end

endmodule

/* verilog/mem_bus_if.sv */
`timescale 1ns/1ps

// Cache controller to main memory
// One-cycle enable per request, reads return on data_valid
interface mem_bus_if;

   logic           enable;
   logic           wr;
   mem_pkg::addr_t addr;
   mem_pkg::word_t wdata;

   // Read return path
   mem_pkg::word_t rdata;
   logic           data_valid;

   // Requester side
   modport ctrl (
      output enable,
      output wr,
      output addr,
      output wdata,
      input  rdata,
      input  data_valid
   );

   // Memory side
   modport mem (
      input  enable,
      input  wr,
      input  addr,
      input  wdata,
      output rdata,
      output data_valid
   );

endinterface

/* verilog/mem_pkg.sv */
// Main memory word and address definitions
// Shared by the memory, the memory bus and the cache

package mem_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   // One data word
   localparam int WORD_BITS = 16;

   // Byte address, bit 0 always zero for word access
   localparam int ADDR_BITS = 16;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////

   typedef logic [WORD_BITS-1:0] word_t;

   typedef logic [ADDR_BITS-1:0] addr_t;

endpackage
